/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [REG_ADDR_W-1:0] regAddr_t;

   // major opcodes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_HALT   = 7'b1111111;

   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_SLTU    = 3'b011;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_SR      = 3'b101;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [2:0] F3_WORD    = 3'b010; // lw / sw width

   localparam logic [6:0] F7_BASE    = 7'b0000000;
   localparam logic [6:0] F7_ALT     = 7'b0100000; // sub, sra

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_OR,
      ALU_AND,
      ALU_SLT,
      ALU_SLTU,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_PASSB
   } aluOp_t;

   typedef enum logic [2:0] {
      CLS_ALU,
      CLS_LUI,
      CLS_LOAD,
      CLS_STORE,
      CLS_HALT,
      CLS_INVALID
   } instClass_t;

   typedef struct packed {
      instClass_t cls;
      aluOp_t     aluOp;
      logic       useImm;
      regAddr_t   rd;
      regAddr_t   rs1;
      regAddr_t   rs2;
      word_t      imm;
   } decodedInst_t;

   typedef struct packed {
      logic     en;
      regAddr_t addr;
      word_t    data;
   } regWrite_t;

   typedef struct packed {
      word_t addr;  // word address
      word_t wData;
      logic  wEn;
   } busCmd_t;

endpackage

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
   input  cpuPkg::word_t  a,
   input  cpuPkg::word_t  b,
   input  cpuPkg::aluOp_t op,
   output cpuPkg::word_t  result
);
   import cpuPkg::*;

   logic [4:0] shamt;
   logic       lessSigned;
   logic       lessUnsigned;

   assign shamt        = b[4:0]; // only low five bits count
   assign lessSigned   = $signed(a) < $signed(b);
   assign lessUnsigned = a < b;

   always_comb begin
      case (op)
         ALU_ADD:   result = a + b;
         ALU_SUB:   result = a - b;
         ALU_XOR:   result = a ^ b;
         ALU_OR:    result = a | b;
         ALU_AND:   result = a & b;
         ALU_SLT:   result = {{(XLEN-1){1'b0}}, lessSigned};
         ALU_SLTU:  result = {{(XLEN-1){1'b0}}, lessUnsigned};
         ALU_SLL:   result = a << shamt;
         ALU_SRL:   result = a >> shamt;
         ALU_SRA:   result = $signed(a) >>> shamt;
         ALU_PASSB: result = b;  // lui
         default:   result = '0;
      endcase
   end

endmodule

`default_nettype wire

/* instDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instDecoder (
   input  cpuPkg::word_t        instr,
   output cpuPkg::decodedInst_t dec
);
   import cpuPkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      immI;
   word_t      immS;
   word_t      immU;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immU = {instr[31:12], 12'h000};

   always_comb begin
      dec.cls    = CLS_INVALID;
      dec.aluOp  = ALU_ADD;
      dec.useImm = 1'b0;
      dec.rd     = instr[11:7];
      dec.rs1    = instr[19:15];
      dec.rs2    = instr[24:20];
      dec.imm    = immI;

      case (opcode)
         OPC_OP: begin
            dec.cls = CLS_ALU;
            if (funct7 == F7_BASE) begin
               case (funct3)
                  F3_ADD_SUB: dec.aluOp = ALU_ADD;
                  F3_SLL:     dec.aluOp = ALU_SLL;
                  F3_SLT:     dec.aluOp = ALU_SLT;
                  F3_SLTU:    dec.aluOp = ALU_SLTU;
                  F3_XOR:     dec.aluOp = ALU_XOR;
                  F3_SR:      dec.aluOp = ALU_SRL;
                  F3_OR:      dec.aluOp = ALU_OR;
                  F3_AND:     dec.aluOp = ALU_AND;
               endcase
            end
            else if (funct7 == F7_ALT && funct3 == F3_ADD_SUB) begin
               dec.aluOp = ALU_SUB;
            end
            else if (funct7 == F7_ALT && funct3 == F3_SR) begin
               dec.aluOp = ALU_SRA;
            end
            else begin
               dec.cls = CLS_INVALID;
            end
         end
         OPC_OP_IMM: begin
            dec.cls    = CLS_ALU;
            dec.useImm = 1'b1;
            case (funct3)
               F3_ADD_SUB: dec.aluOp = ALU_ADD;
               F3_SLT:     dec.aluOp = ALU_SLT;
               F3_SLTU:    dec.aluOp = ALU_SLTU;
               F3_XOR:     dec.aluOp = ALU_XOR;
               F3_OR:      dec.aluOp = ALU_OR;
               F3_AND:     dec.aluOp = ALU_AND;
               F3_SLL: begin
                  dec.aluOp = ALU_SLL;
                  if (funct7 != F7_BASE) dec.cls = CLS_INVALID;
               end
               F3_SR: begin
                  // funct7 picks logical or arithmetic
                  if (funct7 == F7_BASE) dec.aluOp = ALU_SRL;
                  else if (funct7 == F7_ALT) dec.aluOp = ALU_SRA;
                  else dec.cls = CLS_INVALID;
               end
               default: dec.cls = CLS_INVALID;
            endcase
         end
         OPC_LUI: begin
            dec.cls    = CLS_LUI;
            dec.aluOp  = ALU_PASSB;
            dec.useImm = 1'b1;
            dec.imm    = immU;
         end
         OPC_LOAD: begin
            dec.useImm = 1'b1;  // address is rs1 + imm
            if (funct3 == F3_WORD) dec.cls = CLS_LOAD;
         end
         OPC_STORE: begin
            dec.useImm = 1'b1;
            dec.imm    = immS;
            if (funct3 == F3_WORD) dec.cls = CLS_STORE;
         end
         OPC_HALT: dec.cls = CLS_HALT;
         default:  dec.cls = CLS_INVALID;
      endcase
   end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ns
`default_nettype none

module regFile (
   input  logic              clk,
   input  logic              rstn,
   input  cpuPkg::regAddr_t  rs1,
   input  cpuPkg::regAddr_t  rs2,
   output cpuPkg::word_t     rData1,
   output cpuPkg::word_t     rData2,
   input  cpuPkg::regWrite_t wr
);
   import cpuPkg::*;

   word_t regs [1:31]; // x0 has no storage

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end
      else if (wr.en && wr.addr != '0) begin
         regs[wr.addr] <= wr.data;
      end
   end

   // combinational read, x0 reads zero
   assign rData1 = (rs1 == '0) ? '0 : regs[rs1];
   assign rData2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* coreCtrl.sv */
`timescale 1ns/1ns
`default_nettype none

module coreCtrl (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 start,
   output logic                 halt,
   output logic                 memReq,
   output cpuPkg::busCmd_t      memCmd,
   input  logic                 memVld,
   input  cpuPkg::word_t        memRData,
   output cpuPkg::word_t        instr,
   input  cpuPkg::decodedInst_t dec,
   input  cpuPkg::word_t        aluResult,
   input  cpuPkg::word_t        rData2,
   output cpuPkg::regWrite_t    wr
);
   import cpuPkg::*;

   typedef enum logic [1:0] {
      S_HALT,
      S_FETCH,
      S_EXEC,
      S_MEM
   } state_t;

   state_t state;
   word_t  pc;
   word_t  ir;
   word_t  cmdAddr;
   word_t  cmdWData;
   logic   cmdWEn;
   logic   busDone;
   logic   aluClass;
   logic   memClass;
   logic   fetchNow;
   logic   memNow;

   assign instr  = ir;
   assign halt   = (state == S_HALT);
   assign memCmd = '{addr: cmdAddr, wData: cmdWData, wEn: cmdWEn};

   assign busDone  = memReq && memVld;
   assign aluClass = (dec.cls == CLS_ALU) || (dec.cls == CLS_LUI);
   assign memClass = (dec.cls == CLS_LOAD) || (dec.cls == CLS_STORE);

   // fetch request goes out at this edge
   assign fetchNow = (state == S_HALT && start) ||
                     (state == S_EXEC && aluClass) ||
                     (state == S_FETCH && !memReq);  // after a memory phase
   assign memNow   = (state == S_EXEC) && memClass;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state  <= S_HALT;
         pc     <= '0;
         memReq <= 1'b0;
         cmdWEn <= 1'b0;
      end
      else begin
         case (state)
            S_HALT: begin
               if (start) state <= S_FETCH;
            end
            S_FETCH: begin
               if (busDone) begin
                  state <= S_EXEC;
                  pc    <= pc + 1'b1;  // word counter
               end
            end
            S_EXEC: begin
               if (aluClass) state <= S_FETCH;
               else if (memClass) state <= S_MEM;
               else state <= S_HALT;  // halt opcode or invalid
            end
            S_MEM: begin
               if (busDone) state <= S_FETCH;
            end
            default: state <= S_HALT;
         endcase

         // request drops for one cycle after each valid
         if (busDone) memReq <= 1'b0;
         else if (fetchNow || memNow) memReq <= 1'b1;

         if (busDone) cmdWEn <= 1'b0;
         else if (memNow) cmdWEn <= (dec.cls == CLS_STORE);
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_FETCH && busDone) ir <= memRData;

      if (fetchNow) begin
         cmdAddr  <= pc;
         cmdWData <= '0;
      end
      else if (memNow) begin
         cmdAddr  <= aluResult;  // rs1 + imm
         cmdWData <= rData2;
      end
   end

   // write-back lands on the edge closing execute or the load's valid
   // lui passes its immediate through the alu
   always_comb begin
      wr.en   = 1'b0;
      wr.addr = dec.rd;
      case (dec.cls)
         CLS_LOAD: wr.data = memRData;
         default:  wr.data = aluResult;
      endcase
      if (state == S_EXEC && aluClass) wr.en = 1'b1;
      if (state == S_MEM && busDone && dec.cls == CLS_LOAD) wr.en = 1'b1;
   end

endmodule

`default_nettype wire

/* cpuTop.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuTop (
   input  logic            clk,
   input  logic            rstn,
   input  logic            start,
   output logic            halt,
   output logic            memReq,
   output cpuPkg::busCmd_t memCmd,
   input  logic            memVld,
   input  cpuPkg::word_t   memRData
);
   import cpuPkg::*;

   word_t        instr;
   decodedInst_t dec;
   word_t        rData1;
   word_t        rData2;
   word_t        aluB;
   word_t        aluResult;
   regWrite_t    wr;

   // second operand: immediate or rs2
   assign aluB = dec.useImm ? dec.imm : rData2;

   coreCtrl uCtrl (
      .clk       (clk),
      .rstn      (rstn),
      .start     (start),
      .halt      (halt),
      .memReq    (memReq),
      .memCmd    (memCmd),
      .memVld    (memVld),
      .memRData  (memRData),
      .instr     (instr),
      .dec       (dec),
      .aluResult (aluResult),
      .rData2    (rData2),
      .wr        (wr)
   );

   instDecoder uDec (
      .instr (instr),
      .dec   (dec)
   );

   regFile uRegs (
      .clk    (clk),
      .rstn   (rstn),
      .rs1    (dec.rs1),
      .rs2    (dec.rs2),
      .rData1 (rData1),
      .rData2 (rData2),
      .wr     (wr)
   );

   alu uAlu (
      .a      (rData1),
      .b      (aluB),
      .op     (dec.aluOp),
      .result (aluResult)
   );

endmodule

`default_nettype wire

/* tbProgram.svh */
// progTable holds one instruction word per word address, op and its store share a line
// expWrites columns are the store word address and the stored data
localparam int PROG_LEN    = 54;
localparam int NUM_WRITES  = 24;
localparam int HALT_WRITES = 23;  // stores ahead of the halt opcode
localparam int DATA_ADDR   = 100;
localparam logic [31:0] DATA_WORD = 32'h5EED_1234;

word_t progTable [PROG_LEN] = '{
   iType(3'b000, 1, 0, -7), iType(3'b000, 2, 0, 5),      // x1 = -7, x2 = 5
   luiInst(3, 'h80000), iType(3'b000, 3, 3, 'h123),      // x3 = 0x80000123
   rType(7'h00, 3'b000, 4, 1, 2), swInst(4, 0, 64),      // add
   rType(7'h20, 3'b000, 4, 2, 1), swInst(4, 0, 65),      // sub
   rType(7'h00, 3'b100, 4, 1, 3), swInst(4, 0, 66),      // xor
   rType(7'h00, 3'b110, 4, 2, 3), swInst(4, 0, 67),      // or
   rType(7'h00, 3'b111, 4, 1, 3), swInst(4, 0, 68),      // and
   rType(7'h00, 3'b010, 4, 1, 2), swInst(4, 0, 69),      // slt -7 < 5
   rType(7'h00, 3'b010, 4, 1, 3), swInst(4, 0, 70),      // slt, both negative
   rType(7'h00, 3'b011, 4, 1, 2), swInst(4, 0, 71),      // sltu
   rType(7'h00, 3'b001, 4, 3, 2), swInst(4, 0, 72),      // sll by 5
   rType(7'h00, 3'b101, 4, 3, 2), swInst(4, 0, 73),      // srl
   rType(7'h20, 3'b101, 4, 3, 2), swInst(4, 0, 74),      // sra
   rType(7'h00, 3'b001, 4, 3, 1), swInst(4, 0, 75),      // amount 25 from low bits of -7
   iType(3'b000, 5, 1, -100), swInst(5, 0, 76),          // addi
   iType(3'b100, 5, 2, -1), swInst(5, 0, 77),            // xori
   iType(3'b110, 5, 2, 'h7F0), swInst(5, 0, 78),         // ori
   iType(3'b111, 5, 1, 'hF0), swInst(5, 0, 79),          // andi
   iType(3'b010, 5, 1, -6), swInst(5, 0, 80),            // slti
   iType(3'b011, 5, 2, -1), swInst(5, 0, 81),            // sltiu against all ones
   iType(3'b001, 5, 2, 28), swInst(5, 0, 82),            // slli
   iType(3'b101, 5, 1, 4), swInst(5, 0, 83),             // srli
   iType(3'b101, 5, 1, 'h401), swInst(5, 0, 84),         // srai by 1
   lwInst(6, 0, DATA_ADDR), swInst(6, 0, 85),            // copy of the data word
   iType(3'b000, 0, 0, 123), swInst(0, 0, 86),           // x0 stays zero
   32'hFFFF_FFFF,                                        // halt opcode
   swInst(5, 0, 87),                                     // first word after restart
   32'h0000_0000,                                        // invalid, halts again
   swInst(4, 0, 88)                                      // never reached
};

busCmd_t expWrites [NUM_WRITES] = '{
   storeCmd(64, 32'hFFFF_FFFE), storeCmd(65, 32'h0000_000C),
   storeCmd(66, 32'h7FFF_FEDA), storeCmd(67, 32'h8000_0127),
   storeCmd(68, 32'h8000_0121), storeCmd(69, 32'h0000_0001),
   storeCmd(70, 32'h0000_0000), storeCmd(71, 32'h0000_0000),
   storeCmd(72, 32'h0000_2460), storeCmd(73, 32'h0400_0009),
   storeCmd(74, 32'hFC00_0009), storeCmd(75, 32'h4600_0000),
   storeCmd(76, 32'hFFFF_FF95), storeCmd(77, 32'hFFFF_FFFA),
   storeCmd(78, 32'h0000_07F5), storeCmd(79, 32'h0000_00F0),
   storeCmd(80, 32'h0000_0001), storeCmd(81, 32'h0000_0001),
   storeCmd(82, 32'h5000_0000), storeCmd(83, 32'h0FFF_FFFF),
   storeCmd(84, 32'hFFFF_FFFC), storeCmd(85, DATA_WORD),
   storeCmd(86, 32'h0000_0000), storeCmd(87, 32'hFFFF_FFFC)
};

/* tbCpu.sv */
`timescale 1ns/1ns
`default_nettype none

module tbCpu;
   import cpuPkg::*;

   localparam int          MEM_WORDS = 128;
   localparam logic [15:0] LFSR_SEED = 16'd54815;
   localparam busCmd_t     FIRST_FETCH = '{addr: '0, wData: '0, wEn: 1'b0};

   logic        clk;
   logic        rstn;
   logic        start;
   logic        halt;
   logic        memReq;
   busCmd_t     memCmd;
   logic        memVld;
   word_t       memRData;
   word_t       mem [MEM_WORDS];
   logic [15:0] lfsr;
   logic        serving;
   logic [1:0]  waitLeft;
   int          writeIdx;
   int          cycles;

   // instruction formats of the base ISA
   function automatic word_t rType(input logic [6:0] f7, input logic [2:0] f3,
                                   input int rd, input int rs1, input int rs2);
      return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
   endfunction

   function automatic word_t iType(input logic [2:0] f3, input int rd, input int rs1,
                                   input int imm);
      return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
   endfunction

   function automatic word_t lwInst(input int rd, input int rs1, input int imm);
      return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
   endfunction

   function automatic word_t swInst(input int rs2, input int rs1, input int imm);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic word_t luiInst(input int rd, input int imm);
      return {imm[19:0], rd[4:0], 7'b0110111};
   endfunction

   function automatic busCmd_t storeCmd(input int addr, input word_t data);
      return '{addr: word_t'(addr), wData: data, wEn: 1'b1};
   endfunction

   function automatic logic [15:0] nextLfsr(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11
   endfunction

   `include "tbProgram.svh"

   // two bus phases of up to 4 cycles each, plus execute and return
   localparam int TIMEOUT_CYCLES = PROG_LEN * 12 + 50;

   cpuTop dut (
      .clk      (clk),
      .rstn     (rstn),
      .start    (start),
      .halt     (halt),
      .memReq   (memReq),
      .memCmd   (memCmd),
      .memVld   (memVld),
      .memRData (memRData)
   );

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkWrite(input busCmd_t got, input busCmd_t exp);
      if (got !== exp) begin
         failRun($sformatf(
            "[FAIL] t=%0t bus addr %0d data %h wEn %b, expected addr %0d data %h wEn %b",
            $time, got.addr, got.wData, got.wEn, exp.addr, exp.wData, exp.wEn));
      end
   endtask

   task automatic checkHalt(input logic got, input logic exp);
      if (got !== exp) begin
         failRun($sformatf("[FAIL] t=%0t halt is %b, expected %b", $time, got, exp));
      end
   endtask

   task automatic noRequest();
      if (memReq !== 1'b0) begin
         failRun($sformatf("[FAIL] t=%0t memReq is %b while halted", $time, memReq));
      end
   endtask

   task automatic pulseStart();
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
   endtask

   task automatic runToHalt();
      while (halt !== 1'b1) begin
         @(posedge clk);
         #1;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      failRun($sformatf("timeout, the core did not finish within %0d cycles", TIMEOUT_CYCLES));
   end

   // memory model, answers after 0 to 3 idle cycles
   initial begin
      memVld   = 1'b0;
      memRData = '0;
      serving  = 1'b0;
      waitLeft = 2'd0;
      writeIdx = 0;
      lfsr     = LFSR_SEED;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = 32'hA500_0000 ^ (i * 32'h0001_0101);
      end
      for (int i = 0; i < PROG_LEN; i++) begin
         mem[i] = progTable[i];
      end
      mem[DATA_ADDR] = DATA_WORD;
      forever begin
         @(posedge clk);
         #1;
         memVld = 1'b0;
         if (memReq && !serving) begin
            serving     = 1'b1;
            lfsr        = nextLfsr(lfsr);
            waitLeft[0] = lfsr[0];
            lfsr        = nextLfsr(lfsr);
            waitLeft[1] = lfsr[0];
         end
         if (serving && waitLeft != 2'd0) begin
            waitLeft = waitLeft - 1'b1;
         end
         else if (serving) begin
            if (memCmd.addr >= MEM_WORDS) begin
               failRun($sformatf("bus access at word %0d is outside the memory", memCmd.addr));
            end
            if (memCmd.wEn) begin
               if (writeIdx >= NUM_WRITES) begin
                  failRun("the core wrote more words than the program stores");
               end
               checkWrite(memCmd, expWrites[writeIdx]);
               mem[memCmd.addr[6:0]] = memCmd.wData;
               writeIdx++;
            end
            else begin
               memRData = mem[memCmd.addr[6:0]];
            end
            memVld  = 1'b1;
            serving = 1'b0;
         end
      end
   end

   initial begin
      rstn  = 1'b0;
      start = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rstn = 1'b1;
      repeat (10) begin  // idle and halted until start
         @(posedge clk);
         #1;
         checkHalt(halt, 1'b1);
         noRequest();
      end
      pulseStart();
      checkHalt(halt, 1'b0);
      if (memReq !== 1'b1) begin
         failRun($sformatf("[FAIL] t=%0t no fetch request after start", $time));
      end
      checkWrite(memCmd, FIRST_FETCH);
      runToHalt();
      if (writeIdx != HALT_WRITES) begin
         failRun($sformatf("halted after %0d stores instead of %0d", writeIdx, HALT_WRITES));
      end
      repeat (5) begin
         @(posedge clk);
         #1;
         checkHalt(halt, 1'b1);
         noRequest();
      end
      // resume at the word after the halt opcode
      pulseStart();
      checkHalt(halt, 1'b0);
      runToHalt();
      repeat (5) begin
         @(posedge clk);
         #1;
         noRequest();
      end
      if (writeIdx != NUM_WRITES) begin
         failRun($sformatf("saw %0d stores in total, expected %0d", writeIdx, NUM_WRITES));
      end
      else begin
         $display("TEST RESULT: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
cpuPkg.sv
alu.sv
instDecoder.sv
regFile.sv
coreCtrl.sv
cpuTop.sv
tbCpu.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary -f verilog.f --top-module tbCpu -o simCpu > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simCpu > sim.log 2>&1
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }
